// ==== verilog/l1d_cfg.svh ====
/*
 * Geometry and width macros for the L1 data cache
 * Address split is tag | index | offset
 */
`ifndef L1D_CFG_SVH
`define L1D_CFG_SVH

// Address and data widths
`define L1D_ADDR_BITS   32
`define L1D_WORD_BITS   32

// Address fields
`define L1D_INDEX_BITS  6
`define L1D_OFFSET_BITS 4
`define L1D_TAG_BITS    (`L1D_ADDR_BITS - `L1D_INDEX_BITS - `L1D_OFFSET_BITS)

// Line organisation
`define L1D_LINE_WORDS  4
`define L1D_LINES       (1 << `L1D_INDEX_BITS)
`define L1D_LINE_BITS   (`L1D_LINE_WORDS * `L1D_WORD_BITS)

`endif

// ==== verilog/l1d_pkg.sv ====
/*
 * Vector typedefs, access-type codes and controller states
 */
`default_nettype none

`include "l1d_cfg.svh"

package l1d_pkg;

  typedef logic [`L1D_ADDR_BITS-1:0]             addr_t;
  typedef logic [`L1D_WORD_BITS-1:0]             word_t;
  typedef logic [`L1D_TAG_BITS-1:0]              tag_t;
  typedef logic [`L1D_INDEX_BITS-1:0]            index_t;
  typedef logic [`L1D_LINE_BITS-1:0]             line_t;
  typedef logic [$clog2(`L1D_LINE_WORDS)-1:0]    word_sel_t;
  typedef logic [`L1D_WORD_BITS/8-1:0]           byte_mask_t;

  // Core access codes, unsigned forms set bit 2
  typedef enum logic [2:0] {
    acc_byte   = 3'b000,
    acc_half   = 3'b001,
    acc_word   = 3'b010,
    acc_byte_u = 3'b100,
    acc_half_u = 3'b101
  } access_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_refill,   // Four read beats
    st_fill,
    st_write     // Single write-through beat
  } l1d_state_t;

endpackage

`default_nettype wire

// ==== verilog/l1d_store_align.sv ====
/*
 * Store byte-lane mask and lane-replicated write data
 */
`timescale 1ns/1ps
`default_nettype none

module l1d_store_align
  import l1d_pkg::*;
(
  input  wire addr_t   req_addr,
  input  wire word_t   req_data,
  input  wire access_t req_type,
  output byte_mask_t   store_mask,
  output word_t        store_word
);

  always_comb
  begin
    case (req_type)
      acc_byte, acc_byte_u:
      begin
        store_mask = byte_mask_t'(1) << req_addr[1:0];
        store_word = {4{req_data[7:0]}};
      end
      acc_half, acc_half_u:
      begin
        store_mask = req_addr[1] ? 4'b1100 : 4'b0011;   // Upper or lower half
        store_word = {2{req_data[15:0]}};
      end
      acc_word:
      begin
        store_mask = 4'b1111;
        store_word = req_data;
      end
      default:
      begin
        // Unknown code writes no lane
        store_mask = '0;
        store_word = req_data;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/l1d_tag_store.sv ====
/*
 * Valid bits and tag RAM
 * Registered lookup with hit compare against the request tag
 */
`timescale 1ns/1ps
`default_nettype none

`include "l1d_cfg.svh"

module l1d_tag_store
  import l1d_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         lookup_en,
  input  wire index_t lookup_index,
  input  wire addr_t  req_addr,
  input  wire         fill_en,
  input  wire tag_t   fill_tag,
  output logic        hit
);

  logic [`L1D_LINES-1:0] valid;
  tag_t                  tag_ram [`L1D_LINES];
  tag_t                  tag_q;
  logic                  valid_q;
  index_t                fill_index;

  assign fill_index = req_addr[`L1D_OFFSET_BITS +: `L1D_INDEX_BITS];

  // Valid bits clear on reset
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (fill_en)
        valid[fill_index] <= 1'b1;
      if (lookup_en)
        valid_q <= valid[lookup_index];
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_en)
      tag_ram[fill_index] <= fill_tag;
    if (lookup_en)
      tag_q <= tag_ram[lookup_index];   // One cycle read
  end

  assign hit = valid_q && (tag_q == req_addr[`L1D_ADDR_BITS-1 -: `L1D_TAG_BITS]);

endmodule

`default_nettype wire

// ==== verilog/l1d_data_store.sv ====
/*
 * Line data RAM with byte-masked word write
 * Registered line read and word select by offset
 */
`timescale 1ns/1ps
`default_nettype none

`include "l1d_cfg.svh"

module l1d_data_store
  import l1d_pkg::*;
(
  input  wire             clk,
  input  wire             lookup_en,
  input  wire index_t     lookup_index,
  input  wire addr_t      req_addr,
  input  wire             fill_en,
  input  wire line_t      fill_line,
  input  wire             hit_write_en,
  input  wire byte_mask_t store_mask,
  input  wire word_t      store_word,
  output word_t           hit_word
);

  line_t     line_ram [`L1D_LINES];
  line_t     line_q;
  index_t    wr_index;
  word_sel_t word_sel;

  assign wr_index = req_addr[`L1D_OFFSET_BITS +: `L1D_INDEX_BITS];
  assign word_sel = req_addr[`L1D_OFFSET_BITS-1 -: $bits(word_sel_t)];

  always_ff @(posedge clk)
  begin
    if (fill_en)
      line_ram[wr_index] <= fill_line;
    else if (hit_write_en)
    begin
      for (int b = 0; b < $bits(byte_mask_t); b++)
        if (store_mask[b])
          line_ram[wr_index][word_sel*`L1D_WORD_BITS + b*8 +: 8] <= store_word[b*8 +: 8];
    end
    if (lookup_en)
      line_q <= line_ram[lookup_index];
  end

  // Word of the registered line
  assign hit_word = line_q[word_sel*`L1D_WORD_BITS +: `L1D_WORD_BITS];

endmodule

`default_nettype wire

// ==== verilog/l1d_control.sv ====
/*
 * Cache controller FSM
 * Lookup, four-beat refill, line fill and write-through
 */
`timescale 1ns/1ps
`default_nettype none

`include "l1d_cfg.svh"

module l1d_control
  import l1d_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  // Core side
  input  wire          core_req,
  input  wire          core_write,
  input  wire addr_t   core_addr,
  input  wire word_t   core_in,
  input  wire access_t core_type,
  output word_t        core_out,
  output logic         core_wait,
  // Memory side
  output logic         mem_req,
  output logic         mem_write,
  output addr_t        mem_addr,
  output access_t      mem_type,
  input  wire word_t   mem_out,
  input  wire          mem_wait,
  // Storage blocks
  input  wire          hit,
  input  wire word_t   hit_word,
  output logic         lookup_en,
  output index_t       lookup_index,
  output logic         fill_en,
  output tag_t         fill_tag,
  output line_t        fill_line,
  output logic         hit_write_en,
  output addr_t        req_addr,
  output word_t        req_data,
  output access_t      req_type
);

  l1d_state_t state;
  l1d_state_t state_next;
  logic       req_write;
  logic       hit_q;
  word_sel_t  beat_cnt;
  word_sel_t  req_word;
  logic       beat_done;

  assign beat_done = mem_req && !mem_wait;
  assign req_word  = req_addr[`L1D_OFFSET_BITS-1 -: $bits(word_sel_t)];

  // ==========================================================
  // State sequencing
  // ==========================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= st_idle;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      st_idle:
        if (core_req)
          state_next = st_lookup;
      st_lookup:
        if (req_write)
          state_next = st_write;   // Hit or miss, store goes to memory
        else if (hit)
          state_next = st_idle;
        else
          state_next = st_refill;
      st_refill:
        if (beat_done && beat_cnt == word_sel_t'(`L1D_LINE_WORDS - 1))
          state_next = st_fill;
      st_fill:
        state_next = st_idle;
      st_write:
        if (beat_done)
          state_next = st_idle;
      default:
        state_next = st_idle;
    endcase
  end

  // ==========================================================
  // Request capture and refill line
  // ==========================================================
  always_ff @(posedge clk)
  begin
    if (state == st_idle && core_req)
    begin
      req_addr  <= core_addr;
      req_data  <= core_in;
      req_type  <= core_type;
      req_write <= core_write;
    end
    if (state == st_refill && beat_done)
      fill_line <= {mem_out, fill_line[`L1D_LINE_BITS-1:`L1D_WORD_BITS]};   // Word 0 ends lowest
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      beat_cnt <= '0;
      hit_q    <= 1'b0;
      core_out <= '0;
    end
    else
    begin
      case (state)
        st_lookup:
        begin
          hit_q    <= hit;
          beat_cnt <= '0;
          if (hit && !req_write)
            core_out <= hit_word;
        end
        st_refill:
          if (beat_done)
          begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == req_word)
              core_out <= mem_out;   // Requested word on its beat
          end
        default:
          ;
      endcase
    end
  end

  // Port and storage controls
  assign core_wait    = (state != st_idle);
  assign mem_req      = (state == st_refill) || (state == st_write);
  assign mem_write    = (state == st_write);
  assign mem_type     = req_type;
  assign mem_addr     = (state == st_refill) ?
                        {req_addr[`L1D_ADDR_BITS-1:`L1D_OFFSET_BITS], beat_cnt,
                         {(`L1D_OFFSET_BITS - $bits(word_sel_t)){1'b0}}} :
                        req_addr;
  assign lookup_en    = (state == st_idle) && core_req;
  assign lookup_index = core_addr[`L1D_OFFSET_BITS +: `L1D_INDEX_BITS];
  assign fill_en      = (state == st_fill);
  assign fill_tag     = req_addr[`L1D_ADDR_BITS-1 -: `L1D_TAG_BITS];
  assign hit_write_en = (state == st_write) && beat_done && hit_q;

endmodule

`default_nettype wire

// ==== verilog/l1d_top.sv ====
/*
 * L1 data cache top level
 * Controller, tag store, data store and store lane alignment
 */
`timescale 1ns/1ps
`default_nettype none

module l1d_top
  import l1d_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  // Core port
  input  wire          core_req,
  input  wire          core_write,
  input  wire addr_t   core_addr,
  input  wire word_t   core_in,
  input  wire access_t core_type,
  output word_t        core_out,
  output logic         core_wait,
  // Memory port
  output logic         mem_req,
  output logic         mem_write,
  output addr_t        mem_addr,
  output word_t        mem_in,
  output access_t      mem_type,
  input  wire word_t   mem_out,
  input  wire          mem_wait
);

  logic       lookup_en;
  index_t     lookup_index;
  logic       fill_en;
  tag_t       fill_tag;
  line_t      fill_line;
  logic       hit_write_en;
  logic       hit;
  word_t      hit_word;
  addr_t      req_addr;
  word_t      req_data;
  access_t    req_type;
  byte_mask_t store_mask;
  word_t      store_word;

  // ==========================================================
  // Controller
  // ==========================================================
  l1d_control u_control (
    .clk          (clk),
    .rst          (rst),
    .core_req     (core_req),
    .core_write   (core_write),
    .core_addr    (core_addr),
    .core_in      (core_in),
    .core_type    (core_type),
    .core_out     (core_out),
    .core_wait    (core_wait),
    .mem_req      (mem_req),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_type     (mem_type),
    .mem_out      (mem_out),
    .mem_wait     (mem_wait),
    .hit          (hit),
    .hit_word     (hit_word),
    .lookup_en    (lookup_en),
    .lookup_index (lookup_index),
    .fill_en      (fill_en),
    .fill_tag     (fill_tag),
    .fill_line    (fill_line),
    .hit_write_en (hit_write_en),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .req_type     (req_type)
  );

  // ==========================================================
  // Storage
  // ==========================================================
  l1d_tag_store u_tag_store (
    .clk          (clk),
    .rst          (rst),
    .lookup_en    (lookup_en),
    .lookup_index (lookup_index),
    .req_addr     (req_addr),
    .fill_en      (fill_en),
    .fill_tag     (fill_tag),
    .hit          (hit)
  );

  l1d_data_store u_data_store (
    .clk          (clk),
    .lookup_en    (lookup_en),
    .lookup_index (lookup_index),
    .req_addr     (req_addr),
    .fill_en      (fill_en),
    .fill_line    (fill_line),
    .hit_write_en (hit_write_en),
    .store_mask   (store_mask),
    .store_word   (store_word),
    .hit_word     (hit_word)
  );

  l1d_store_align u_store_align (
    .req_addr   (req_addr),
    .req_data   (req_data),
    .req_type   (req_type),
    .store_mask (store_mask),
    .store_word (store_word)
  );

  assign mem_in = store_word;   // Same lanes as the cached copy

endmodule

`default_nettype wire

// ==== dv/l1d_checker.sv ====
/*
 * Concurrent assertions on the core and memory ports
 * Bound into the cache top level
 */
`timescale 1ns/1ps
`default_nettype none

module l1d_checker
  import l1d_pkg::*;
(
  input wire        clk,
  input wire        rst,
  input wire        core_req,
  input wire        core_wait,
  input wire        mem_req,
  input wire        mem_write,
  input wire addr_t mem_addr,
  input wire word_t mem_in,
  input wire        mem_wait
);

  int unsigned fail_count = 0;

  // Held beat under back-pressure
  mem_hold_a: assert property (@(posedge clk) disable iff (rst)
    (mem_req && mem_wait) |=>
      ($stable(mem_req) && $stable(mem_write) && $stable(mem_addr) && $stable(mem_in)))
  else
  begin
    fail_count++;
    $error("memory port changed while mem_wait was high");
  end

  no_busy_req_a: assert property (@(posedge clk) disable iff (rst)
    core_wait |-> !core_req)
  else
  begin
    fail_count++;
    $error("core_req strobed while the cache was busy");
  end

  mem_after_req_a: assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) |-> $past(core_req, 2))   // Traffic only after an accepted request
  else
  begin
    fail_count++;
    $error("mem_req rose without a core request two cycles earlier");
  end

endmodule

bind l1d_top l1d_checker u_checker (
  .clk       (clk),
  .rst       (rst),
  .core_req  (core_req),
  .core_wait (core_wait),
  .mem_req   (mem_req),
  .mem_write (mem_write),
  .mem_addr  (mem_addr),
  .mem_in    (mem_in),
  .mem_wait  (mem_wait)
);

`default_nettype wire

// ==== dv/l1d_mem_model.sv ====
/*
 * Word memory model for the cache memory port
 * Random wait states, byte-masked writes, refill order check
 */
`timescale 1ns/1ps
`default_nettype none

module l1d_mem_model
  import l1d_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  wire          mem_req,
  input  wire          mem_write,
  input  wire addr_t   mem_addr,
  input  wire word_t   mem_in,
  input  wire access_t mem_type,
  output word_t        mem_out,
  output logic         mem_wait,
  output int unsigned  read_beats,
  output int unsigned  write_beats,
  output logic         order_error,
  output addr_t        last_wr_addr,
  output word_t        last_wr_word
);

  word_t       words [addr_t];   // Keyed by word address
  logic        new_beat;
  int unsigned wait_left;
  int unsigned burst_pos;
  addr_t       burst_base;
  word_t       merged;
  byte_mask_t  mask;

  function automatic word_t init_word(addr_t a);
    addr_t w;
    w = {a[31:2], 2'b00};
    return {w[15:0], w[31:16]} ^ 32'h6c3a_91e5 ^ (w << 3);
  endfunction

  function automatic word_t fetch_word(addr_t a);
    if (words.exists(a >> 2))
      return words[a >> 2];
    return init_word(a);
  endfunction

  function automatic byte_mask_t lane_mask(access_t t, addr_t a);
    case (t)
      acc_byte, acc_byte_u: lane_mask = 4'b0001 << a[1:0];
      acc_half, acc_half_u: lane_mask = a[1] ? 4'b1100 : 4'b0011;
      acc_word:             lane_mask = 4'b1111;
      default:              lane_mask = 4'b0000;
    endcase
  endfunction

  // Wait states and read data change on the falling edge
  initial
  begin
    void'($urandom(32'hb2f4));
    mem_wait  = 1'b0;
    mem_out   = '0;
    wait_left = 0;
    forever
    begin
      @(negedge clk);
      if (!mem_req)
        mem_wait = 1'b0;
      else
      begin
        if (new_beat)
        begin
          wait_left = $urandom % 4;   // 0 to 3 wait cycles
          new_beat  = 1'b0;
        end
        else if (wait_left != 0)
          wait_left--;
        mem_wait = (wait_left != 0);
        mem_out  = fetch_word(mem_addr);
      end
    end
  end

  // ==========================================================
  // Beat completion
  // ==========================================================
  always @(posedge clk)
  begin
    if (rst)
    begin
      read_beats   = 0;
      write_beats  = 0;
      order_error  = 1'b0;
      last_wr_addr = '0;
      last_wr_word = '0;
      new_beat     = 1'b1;
      burst_pos    = 0;
    end
    else if (mem_req && !mem_wait)
    begin
      new_beat = 1'b1;
      if (mem_write)
      begin
        merged = fetch_word(mem_addr);
        mask   = lane_mask(mem_type, mem_addr);
        for (int b = 0; b < 4; b++)
          if (mask[b])
            merged[b*8 +: 8] = mem_in[b*8 +: 8];
        words[mem_addr >> 2] = merged;
        last_wr_addr = mem_addr;
        last_wr_word = merged;
        write_beats++;
      end
      else
      begin
        if (burst_pos == 0)
        begin
          if (mem_addr[3:0] != 4'h0)
            order_error = 1'b1;   // Burst must start line aligned
          burst_base = mem_addr;
        end
        else if (mem_addr != burst_base + 4 * burst_pos)
          order_error = 1'b1;
        burst_pos = (burst_pos + 1) % 4;
        read_beats++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/l1d_tb.sv ====
/*
 * Table-driven testbench for the L1 data cache
 * Reference memory, hit/miss prediction, timeout
 */
`timescale 1ns/1ps
`default_nettype none

module l1d_tb
  import l1d_pkg::*;
();

  typedef struct {
    logic    write;
    addr_t   addr;
    word_t   data;
    access_t kind;
    logic    hit;     // Expected lookup result
  } op_t;

  localparam int NUM_OPS     = 28;
  localparam int OP_CYCLES   = 4 * 4 + 3;   // Worst-case miss
  localparam int CYCLE_LIMIT = (NUM_OPS + 1) * OP_CYCLES;

  logic        clk;
  logic        rst;
  logic        core_req;
  logic        core_write;
  addr_t       core_addr;
  word_t       core_in;
  access_t     core_type;
  word_t       core_out;
  logic        core_wait;
  logic        mem_req;
  logic        mem_write;
  addr_t       mem_addr;
  word_t       mem_in;
  access_t     mem_type;
  word_t       mem_out;
  logic        mem_wait;
  int unsigned read_beats;
  int unsigned write_beats;
  logic        order_error;
  addr_t       last_wr_addr;
  word_t       last_wr_word;

  op_t         ops [NUM_OPS];
  word_t       ref_mem [addr_t];
  logic        ref_valid [64];
  logic [21:0] ref_tag [64];
  word_t       last_read = '0;
  int unsigned cycle_count = 0;

  l1d_top u_l1d_top (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_write (core_write),
    .core_addr  (core_addr),
    .core_in    (core_in),
    .core_type  (core_type),
    .core_out   (core_out),
    .core_wait  (core_wait),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_in     (mem_in),
    .mem_type   (mem_type),
    .mem_out    (mem_out),
    .mem_wait   (mem_wait)
  );

  l1d_mem_model u_mem (
    .clk          (clk),
    .rst          (rst),
    .mem_req      (mem_req),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_in       (mem_in),
    .mem_type     (mem_type),
    .mem_out      (mem_out),
    .mem_wait     (mem_wait),
    .read_beats   (read_beats),
    .write_beats  (write_beats),
    .order_error  (order_error),
    .last_wr_addr (last_wr_addr),
    .last_wr_word (last_wr_word)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, the cache did not finish the table", cycle_count);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  // ==========================================================
  // Reference model
  // ==========================================================
  function automatic word_t init_word(addr_t a);
    addr_t w;
    w = {a[31:2], 2'b00};
    return {w[15:0], w[31:16]} ^ 32'h6c3a_91e5 ^ (w << 3);
  endfunction

  function automatic word_t ref_read(addr_t a);
    if (ref_mem.exists(a >> 2))
      return ref_mem[a >> 2];
    return init_word(a);
  endfunction

  function automatic word_t merge_store(word_t old, addr_t a, word_t d, access_t t);
    word_t res;
    res = old;
    case (t)
      acc_byte, acc_byte_u: res[8 * a[1:0] +: 8] = d[7:0];
      acc_half, acc_half_u: res[16 * a[1] +: 16] = d[15:0];
      acc_word:             res = d;
      default:              ;
    endcase
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic set_op(input int i, input logic w, input addr_t a, input word_t d,
                        input access_t k, input logic h);
    ops[i] = '{write: w, addr: a, data: d, kind: k, hit: h};
  endtask

  task automatic load_table();
    set_op(0,  0, 32'h0000_1004, 32'h0,          acc_word,   0);
    set_op(1,  0, 32'h0000_100c, 32'h0,          acc_word,   1);
    set_op(2,  0, 32'h0000_1000, 32'h0,          acc_word,   1);
    set_op(3,  1, 32'h0000_1005, 32'h0000_00a5,  acc_byte,   1);
    set_op(4,  0, 32'h0000_1004, 32'h0,          acc_word,   1);
    set_op(5,  1, 32'h0000_100e, 32'h0000_beef,  acc_half,   1);
    set_op(6,  0, 32'h0000_100c, 32'h0,          acc_word,   1);
    set_op(7,  1, 32'h0000_1008, 32'h1234_5678,  acc_word,   1);
    set_op(8,  0, 32'h0000_1008, 32'h0,          acc_word,   1);
    set_op(9,  1, 32'h0000_2023, 32'h0000_003c,  acc_byte,   0);   // Store miss
    set_op(10, 0, 32'h0000_2020, 32'h0,          acc_word,   0);
    set_op(11, 1, 32'h0000_2032, 32'h0000_7e01,  acc_half_u, 0);
    set_op(12, 0, 32'h0000_2030, 32'h0,          acc_word,   0);
    set_op(13, 0, 32'h0000_2024, 32'h0,          acc_word,   1);
    set_op(14, 0, 32'h0000_0040, 32'h0,          acc_word,   0);   // Index 4 conflict
    set_op(15, 0, 32'h0000_0444, 32'h0,          acc_word,   0);
    set_op(16, 0, 32'h0000_0048, 32'h0,          acc_word,   0);
    set_op(17, 0, 32'h0000_044c, 32'h0,          acc_word,   0);
    set_op(18, 0, 32'h0000_0040, 32'h0,          acc_word,   0);
    set_op(19, 1, 32'h0000_0441, 32'h0000_005a,  acc_byte_u, 0);
    set_op(20, 0, 32'h0000_0440, 32'h0,          acc_word,   0);
    set_op(21, 0, 32'h0000_0441, 32'h0,          acc_word,   1);
    set_op(22, 0, 32'hffff_fff0, 32'h0,          acc_word,   0);
    set_op(23, 0, 32'hffff_fffc, 32'h0,          acc_word,   1);
    set_op(24, 1, 32'hffff_fff0, 32'h0000_abcd,  acc_half,   1);
    set_op(25, 0, 32'hffff_fff0, 32'h0,          acc_word,   1);
    set_op(26, 1, 32'h0000_1000, 32'hcafe_f00d,  acc_word,   1);
    set_op(27, 0, 32'h0000_1000, 32'h0,          acc_word,   1);
  endtask

  // ==========================================================
  // One table entry
  // ==========================================================
  task automatic run_op(input op_t op);
    int unsigned rd_start;
    int unsigned wr_start;
    int          busy;
    logic        saw_req;
    int          idx;
    logic [21:0] tag;
    word_t       exp_word;
    idx      = op.addr[9:4];
    tag      = op.addr[31:10];
    rd_start = read_beats;
    wr_start = write_beats;
    check_value("predicted hit", ref_valid[idx] && (ref_tag[idx] == tag), op.hit);
    core_req   = 1'b1;
    core_write = op.write;
    core_addr  = op.addr;
    core_in    = op.data;
    core_type  = op.kind;
    @(negedge clk);
    core_req = 1'b0;
    busy     = 0;
    saw_req  = 1'b0;
    while (core_wait)
    begin
      busy++;
      saw_req = saw_req | mem_req;
      @(negedge clk);
    end
    check_value("checker failures", u_l1d_top.u_checker.fail_count, 0);
    check_value("order_error", order_error, 1'b0);
    if (op.write)
    begin
      exp_word = merge_store(ref_read(op.addr), op.addr, op.data, op.kind);
      ref_mem[op.addr >> 2] = exp_word;   // No allocate, tags untouched
      check_value("write beats", write_beats - wr_start, 1);
      check_value("read beats", read_beats - rd_start, 0);
      check_value("last_wr_addr", last_wr_addr, op.addr);
      check_value("last_wr_word", last_wr_word, exp_word);
      check_value("core_out", core_out, last_read);
      check_value("core_wait cycles >= 2", busy >= 2, 1'b1);
    end
    else
    begin
      exp_word = ref_read(op.addr);
      check_value("core_out", core_out, exp_word);
      check_value("write beats", write_beats - wr_start, 0);
      last_read = exp_word;
      if (op.hit)
      begin
        check_value("read beats", read_beats - rd_start, 0);
        check_value("core_wait cycles", busy, 1);
        check_value("mem_req on hit", saw_req, 1'b0);
      end
      else
      begin
        check_value("read beats", read_beats - rd_start, 4);
        check_value("core_wait cycles >= 6", busy >= 6, 1'b1);
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
      end
    end
  endtask

  initial
  begin
    rst        = 1'b1;
    core_req   = 1'b0;
    core_write = 1'b0;
    core_addr  = '0;
    core_in    = '0;
    core_type  = acc_word;
    for (int i = 0; i < 64; i++)
    begin
      ref_valid[i] = 1'b0;
      ref_tag[i]   = '0;
    end
    load_table();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    check_value("core_wait", core_wait, 1'b0);
    check_value("mem_req", mem_req, 1'b0);
    check_value("mem_write", mem_write, 1'b0);
    check_value("core_out", core_out, 32'h0);
    for (int i = 0; i < NUM_OPS; i++)
      run_op(ops[i]);
    @(negedge clk);
    if (u_l1d_top.u_checker.fail_count == 0)
    begin
      $display(">>> PASS");
      $finish;
    end
    else
    begin
      $display("The port checker reported %0d assertion failures",
               u_l1d_top.u_checker.fail_count);
      $display(">>> FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/l1d_pkg.sv
verilog/l1d_store_align.sv
verilog/l1d_tag_store.sv
verilog/l1d_data_store.sv
verilog/l1d_control.sv
verilog/l1d_top.sv
dv/l1d_checker.sv
dv/l1d_mem_model.sv
dv/l1d_tb.sv
